//--- tb.f
logic/qeciphy_pkg.sv
logic/qeciphy_reset_seq.sv
logic/qeciphy_controller.sv
logic/qeciphy_tx.sv
logic/qeciphy_rx.sv
logic/qeciphy_top.sv
tests/tb_clkgen.sv
tests/tb_qeciphy.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the link PHY testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps -f tb.f \
      --top-module tb_qeciphy -Mdir obj_dir -o sim_qeciphy; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/sim_qeciphy)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$output"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tests/tb_qeciphy.sv
// Testbench top for the link PHY
// Loopback channel model, random traffic, queue model, compare tasks, timeout
`default_nettype none

module tb_qeciphy;
   timeunit 1ns;
   timeprecision 100ps;

   import qeciphy_pkg::*;

   localparam int RESET_CYCLES  = 8;
   localparam int ALIGN_COUNT   = 4;
   localparam int LOCK_COUNT    = 4;
   localparam int FAULT_LIMIT   = 3;
   localparam int N_XFER_CLEAN  = 40;  // Test 2 transfers
   localparam int N_XFER_NOISY  = 20;  // Test 4 transfers
   localparam int N_BURSTS      = 6;   // Short error bursts in test 4
   localparam int HOLD_CYCLES   = 20;  // Fault must persist this long
   localparam int STALL_CYCLES  = 50;  // Remote not ready window
   // Reset hold plus lock runs, with room for pipeline stages
   localparam int BRINGUP_BOUND = RESET_CYCLES + 8 * (ALIGN_COUNT + LOCK_COUNT) + 40;
   localparam int XFER_BOUND    = 30;  // Gap plus one full handshake
   localparam int TIMEOUT_CYCLES = 4 * BRINGUP_BOUND
                                 + (N_XFER_CLEAN + N_XFER_NOISY + 1) * XFER_BOUND
                                 + STALL_CYCLES + HOLD_CYCLES + 400;

   logic            clk;
   logic            rst_n;
   logic            tx_req;
   logic [7:0]      tx_data;
   logic            tx_ack;
   logic            rx_valid;
   logic [7:0]      rx_data;
   logic            link_ready;
   logic            fault_fatal;
   qeciphy_frame_t  tx_frame;
   qeciphy_frame_t  rx_frame;   // Channel output register
   qeciphy_status_e status;

   logic            corrupt_en;  // Flip a payload bit in the channel
   logic            clear_rdy;   // Zero the rdy bit in the channel
   logic [7:0]      model_q[$];  // Bytes expected at rx_valid_o
   int              burst_gap[N_BURSTS];  // Clean cycles before each burst
   int              burst_len[N_BURSTS];  // Corrupted frames per burst
   integer          seed;
   int              err_cnt;
   int              frame_errs;
   int              frame_cnt;
   int              dropped_cnt;
   int              tests_run;
   int              tests_failed;
   int              cycle_cnt;

   tb_clkgen #(.PERIOD_NS(4)) i_clkgen (.clk_o(clk));

   qeciphy_top #(
      .RESET_CYCLES (RESET_CYCLES),
      .ALIGN_COUNT  (ALIGN_COUNT),
      .LOCK_COUNT   (LOCK_COUNT),
      .FAULT_LIMIT  (FAULT_LIMIT)
   ) i_dut (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .tx_frame_o    (tx_frame),
      .rx_frame_i    (rx_frame),
      .tx_req_i      (tx_req),
      .tx_data_i     (tx_data),
      .tx_ack_o      (tx_ack),
      .rx_valid_o    (rx_valid),
      .rx_data_o     (rx_data),
      .link_ready_o  (link_ready),
      .fault_fatal_o (fault_fatal),
      .status_o      (status)
   );

   // ========================================================================
   // Compare and report helpers
   // ========================================================================

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic check_status(input string name, input qeciphy_status_e act,
                               input qeciphy_status_e exp);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, act, exp);
         err_cnt++;
      end
   endtask

   task automatic check_data(input string name, input logic [7:0] act, input logic [7:0] exp);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, act, exp);
         err_cnt++;
      end
   endtask

   task automatic check_frame(input string name, input qeciphy_frame_t act,
                              input qeciphy_frame_t exp);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, act, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s = %b, expected %b", $time, name, act, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs);
      tests_run++;
      if (errs == 0) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", num, name, errs);
      end
   endtask

   // Same frame with the checksum the frame rule demands
   function automatic qeciphy_frame_t with_nibble_check(input qeciphy_frame_t f);
      qeciphy_frame_t e;
      e       = f;
      e.check = f.payload[7:4] ^ f.payload[3:0];
      return e;
   endfunction

   // Position of a status in the bring-up order
   function automatic logic [2:0] status_rank(input qeciphy_status_e s);
      case (s)
         ST_RESET:          return 3'd0;
         ST_WAIT_FOR_RESET: return 3'd1;
         ST_LINK_TRAINING:  return 3'd2;
         ST_RX_LOCKED:      return 3'd3;
         ST_LINK_READY:     return 3'd4;
         default:           return 3'd5;  // Fault or unknown
      endcase
   endfunction

   // ========================================================================
   // Channel model and monitors
   // ========================================================================

   // One register stage in the loopback path
   always @(posedge clk) begin
      qeciphy_frame_t f;
      f = tx_frame;
      if (corrupt_en && f.kind != KIND_NONE) begin
         f.payload[0] = ~f.payload[0];  // Checksum no longer matches
         if (f.kind == KIND_DATA && model_q.size() != 0) begin
            void'(model_q.pop_front());  // Dropped by the receiver
            dropped_cnt++;
         end
      end
      if (clear_rdy) begin
         f.rdy = 1'b0;  // Frame stays valid
      end
      if (!rst_n) begin
         rx_frame <= '0;
      end else begin
         rx_frame <= f;
      end
   end

   // Frame rule and delivery, sampled mid-cycle
   always @(negedge clk) begin
      int e;
      if (rst_n) begin
         e = err_cnt;
         if (tx_frame.kind != KIND_NONE) begin
            frame_cnt++;
            check_frame("tx_frame_o", tx_frame, with_nibble_check(tx_frame));
            if (tx_frame.kind == KIND_DATA && !link_ready) begin
               report_error("data frame on tx_frame_o while link_ready_o is low");
            end
         end
         frame_errs += err_cnt - e;
         if (rx_valid) begin
            if (model_q.size() == 0) begin
               report_error("rx_valid_o pulsed with no byte expected");
            end else begin
               check_data("rx_data_o", rx_data, model_q.pop_front());
            end
         end
      end
   end

   // ========================================================================
   // Stimulus tasks
   // ========================================================================

   task automatic apply_reset();
      @(posedge clk);
      rst_n      <= 1'b0;
      tx_req     <= 1'b0;
      corrupt_en <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // Reset, then follow status_o until the link is ready
   task automatic bring_up();
      logic [2:0] prev_rank;
      logic [2:0] rank;
      logic [7:0] seen;
      int         n;
      apply_reset();
      @(negedge clk);
      check_status("status_o", status, ST_RESET);
      prev_rank = 3'd0;
      seen      = '0;
      n         = 0;
      while (!link_ready && n < BRINGUP_BOUND) begin
         rank = status_rank(status);
         if (rank < prev_rank) begin
            report_error($sformatf("status_o stepped back to %0d", status));
         end
         seen[rank] = 1'b1;
         prev_rank  = rank;
         @(negedge clk);
         n++;
      end
      if (!link_ready) begin
         report_error($sformatf("link did not come up within %0d cycles", BRINGUP_BOUND));
      end else begin
         check_status("status_o", status, ST_LINK_READY);
         seen[4] = 1'b1;
         if (seen[4:0] != 5'b11111) begin
            report_error("bring-up skipped a status step");
         end
      end
   endtask

   // Raise a request and record the byte in the model
   task automatic raise_request(input logic [7:0] data);
      @(posedge clk);
      tx_data <= data;
      tx_req  <= 1'b1;
      model_q.push_back(data);
   endtask

   // Rest of the four-phase handshake
   task automatic finish_request(input int bound);
      int n;
      n = 0;
      @(negedge clk);
      while (!tx_ack && n < bound) begin
         @(negedge clk);
         n++;
      end
      if (!tx_ack) begin
         report_error("tx_ack_o never rose for a request");
      end
      @(posedge clk);
      tx_req <= 1'b0;
      n = 0;
      @(negedge clk);
      while (tx_ack && n < XFER_BOUND) begin
         @(negedge clk);
         n++;
      end
      if (tx_ack) begin
         report_error("tx_ack_o stayed high after the request dropped");
      end
   endtask

   // One four-phase transfer
   task automatic send_byte(input logic [7:0] data);
      raise_request(data);
      finish_request(XFER_BOUND);
   endtask

   task automatic send_bytes(input int count);
      int gap;
      for (int i = 0; i < count; i++) begin
         gap = $random(seed) & 7;
         repeat (gap) @(posedge clk);
         send_byte(8'($random(seed)));
      end
   endtask

   // n consecutive frames corrupted
   task automatic corrupt_frames(input int n);
      @(posedge clk);
      corrupt_en <= 1'b1;
      repeat (n) @(posedge clk);
      corrupt_en <= 1'b0;
   endtask

   // Burst lengths kept below the fault limit
   task automatic draw_bursts();
      for (int i = 0; i < N_BURSTS; i++) begin
         burst_gap[i] = 4 + ($random(seed) & 15);
         burst_len[i] = (($random(seed) & 255) % (FAULT_LIMIT - 1)) + 1;
      end
   endtask

   // Bursts with clean frames between
   task automatic inject_bursts();
      for (int i = 0; i < N_BURSTS; i++) begin
         repeat (burst_gap[i]) @(posedge clk);
         corrupt_frames(burst_len[i]);
      end
   endtask

   task automatic wait_status(input qeciphy_status_e target, input int bound);
      int n;
      n = 0;
      @(negedge clk);
      while (status != target && n < bound) begin
         @(negedge clk);
         n++;
      end
      if (status != target) begin
         report_error($sformatf("status_o never reached %0d within %0d cycles", target, bound));
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (model_q.size() != 0 && n < XFER_BOUND) begin
         @(negedge clk);
         n++;
      end
      if (model_q.size() != 0) begin
         report_error($sformatf("%0d sent bytes were never delivered", model_q.size()));
      end
   endtask

   // ========================================================================
   // Test sequence
   // ========================================================================

   initial begin
      int errs;
      seed         = 32'hbc5b7f37;
      rst_n        = 1'b0;
      tx_req       = 1'b0;
      tx_data      = 8'h00;
      rx_frame     = '0;
      corrupt_en   = 1'b0;
      clear_rdy    = 1'b0;
      err_cnt      = 0;
      frame_errs   = 0;
      frame_cnt    = 0;
      dropped_cnt  = 0;
      tests_run    = 0;
      tests_failed = 0;

      errs = err_cnt;
      bring_up();
      report_test(1, "bring-up order", err_cnt - errs);

      errs = err_cnt;
      send_bytes(N_XFER_CLEAN);
      wait_drain();
      report_test(2, "data transfer", err_cnt - errs);

      // Traffic and short error bursts side by side
      errs = err_cnt;
      draw_bursts();
      fork
         send_bytes(N_XFER_NOISY);
         inject_bursts();
      join
      wait_drain();
      check_flag("fault_fatal_o", fault_fatal, 1'b0);
      check_status("status_o", status, ST_LINK_READY);
      $display("Isolated errors dropped %0d data frames", dropped_cnt);
      report_test(4, "isolated errors", err_cnt - errs);

      errs = err_cnt;
      corrupt_frames(FAULT_LIMIT);
      wait_status(ST_FAULT_FATAL, 10);
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         check_flag("fault_fatal_o", fault_fatal, 1'b1);
         check_flag("link_ready_o", link_ready, 1'b0);
         check_status("status_o", status, ST_FAULT_FATAL);
      end
      bring_up();  // Link must recover after reset
      report_test(5, "fatal fault", err_cnt - errs);

      errs = err_cnt;
      @(posedge clk);
      clear_rdy <= 1'b1;  // Far side never looks locked
      apply_reset();
      wait_status(ST_RX_LOCKED, BRINGUP_BOUND);
      raise_request(8'($random(seed)));  // Held back until link ready
      repeat (STALL_CYCLES) begin
         @(negedge clk);
         check_status("status_o", status, ST_RX_LOCKED);
         check_flag("link_ready_o", link_ready, 1'b0);
         check_flag("tx_ack_o", tx_ack, 1'b0);
      end
      @(posedge clk);
      clear_rdy <= 1'b0;
      wait_status(ST_LINK_READY, BRINGUP_BOUND);
      check_flag("link_ready_o", link_ready, 1'b1);
      finish_request(XFER_BOUND);
      wait_drain();
      report_test(6, "remote not ready", err_cnt - errs);

      $display("Frame rule covered %0d frames", frame_cnt);
      report_test(3, "frame rule", frame_errs);
      $display("Tests run: %0d, tests failed: %0d, errors: %0d",
               tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Run limit from the test lengths
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/tb_clkgen.sv
// Testbench clock source
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS = 4  // Full clock period
) (
   output logic clk_o
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // Even duty cycle
   end

endmodule

`default_nettype wire

//--- logic/qeciphy_top.sv
// PHY top level
// Reset sequencer, controller, framer and deframer wired together
`default_nettype none

module qeciphy_top #(
   parameter int RESET_CYCLES = 8,
   parameter int ALIGN_COUNT  = 4,
   parameter int LOCK_COUNT   = 4,
   parameter int FAULT_LIMIT  = 3
) (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   // Link side
   output qeciphy_pkg::qeciphy_frame_t  tx_frame_o,
   input  qeciphy_pkg::qeciphy_frame_t  rx_frame_i,
   // User transmit, four-phase
   input  wire                          tx_req_i,
   input  wire  [7:0]                   tx_data_i,
   output logic                         tx_ack_o,
   // User receive
   output logic                         rx_valid_o,
   output logic [7:0]                   rx_data_o,
   // Status
   output logic                         link_ready_o,
   output logic                         fault_fatal_o,
   output qeciphy_pkg::qeciphy_status_e status_o
);

   logic reset_done;
   logic rx_aligned;
   logic rx_locked;      // Also sent out in the rdy field
   logic remote_ready;
   logic fault;
   logic tx_link_enable;
   logic tx_data_enable;
   logic rx_enable;

   qeciphy_reset_seq #(
      .RESET_CYCLES (RESET_CYCLES)
   ) i_reset_seq (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .reset_done_o (reset_done)
   );

   qeciphy_controller i_controller (
      .clk_i                 (clk_i),
      .rst_n_i               (rst_n_i),
      .reset_done_i          (reset_done),
      .rx_datapath_aligned_i (rx_aligned),
      .rx_ready_i            (rx_locked),
      .remote_rx_ready_i     (remote_ready),
      .fault_fatal_i         (fault),
      .link_ready_o          (link_ready_o),
      .fault_fatal_o         (fault_fatal_o),
      .tx_link_enable_o      (tx_link_enable),
      .tx_data_enable_o      (tx_data_enable),
      .rx_enable_o           (rx_enable),
      .status_o              (status_o)
   );

   qeciphy_tx i_tx (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .tx_link_enable_i (tx_link_enable),
      .tx_data_enable_i (tx_data_enable),
      .local_rx_ready_i (rx_locked),
      .tx_req_i         (tx_req_i),
      .tx_data_i        (tx_data_i),
      .tx_ack_o         (tx_ack_o),
      .tx_frame_o       (tx_frame_o)
   );

   qeciphy_rx #(
      .ALIGN_COUNT (ALIGN_COUNT),
      .LOCK_COUNT  (LOCK_COUNT),
      .FAULT_LIMIT (FAULT_LIMIT)
   ) i_rx (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .rx_enable_i    (rx_enable),
      .rx_frame_i     (rx_frame_i),
      .aligned_o      (rx_aligned),
      .locked_o       (rx_locked),
      .remote_ready_o (remote_ready),
      .fault_o        (fault),
      .rx_valid_o     (rx_valid_o),
      .rx_data_o      (rx_data_o)
   );

endmodule

`default_nettype wire

//--- logic/qeciphy_rx.sv
// Receive deframer
// Alignment, frame lock, remote ready, loss-of-lock fault, data delivery
`default_nettype none

module qeciphy_rx #(
   parameter int ALIGN_COUNT = 4,  // Training frames to align
   parameter int LOCK_COUNT  = 4,  // Valid frames to lock
   parameter int FAULT_LIMIT = 3   // Bad frames to fault
) (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         rx_enable_i,
   input  qeciphy_pkg::qeciphy_frame_t rx_frame_i,
   output logic                        aligned_o,
   output logic                        locked_o,
   output logic                        remote_ready_o,
   output logic                        fault_o,
   output logic                        rx_valid_o,
   output logic [7:0]                  rx_data_o
);

   import qeciphy_pkg::*;

   // Counter sized for the largest threshold
   localparam int MAX_AL  = (ALIGN_COUNT > LOCK_COUNT) ? ALIGN_COUNT : LOCK_COUNT;
   localparam int MAX_CNT = (MAX_AL > FAULT_LIMIT) ? MAX_AL : FAULT_LIMIT;
   localparam int CNT_W   = $clog2(MAX_CNT + 1);

   typedef enum logic [1:0] {
      HUNT,     // Looking for training
      ALIGNED,  // Training seen, waiting to lock
      LOCKED,   // Frames accepted
      FAULT     // Lock lost, sticky
   } rx_state_e;

   rx_state_e        state;
   logic [CNT_W-1:0] cnt;      // Run length, meaning depends on state
   qeciphy_frame_t   frame_q;  // Input register
   logic             valid;
   logic             is_train;

   // ========================================================================
   // Frame qualification
   // ========================================================================

   assign valid    = frame_valid(frame_q);
   assign is_train = valid && frame_q.kind == KIND_TRAIN && frame_q.payload == TRAIN_PATTERN;

   always_ff @(posedge clk_i) begin
      frame_q <= rx_frame_i;  // Payload register
   end

   always_ff @(posedge clk_i) begin
      rx_data_o <= frame_q.payload;  // Qualified by rx_valid_o
   end

   // ========================================================================
   // Alignment, lock and fault tracking
   // ========================================================================

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state          <= HUNT;
         cnt            <= '0;
         aligned_o      <= 1'b0;
         locked_o       <= 1'b0;
         remote_ready_o <= 1'b0;
         fault_o        <= 1'b0;
         rx_valid_o     <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0;  // Single-cycle pulse
         case (state)
            HUNT: begin
               if (!is_train) begin
                  cnt <= '0;  // Run broken
               end else if (cnt == CNT_W'(ALIGN_COUNT - 1)) begin
                  cnt       <= '0;
                  aligned_o <= 1'b1;
                  state     <= ALIGNED;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ALIGNED: begin
               // Lock count only runs once the controller allows it
               if (!rx_enable_i || !valid) begin
                  cnt <= '0;
               end else if (cnt == CNT_W'(LOCK_COUNT - 1)) begin
                  cnt      <= '0;
                  locked_o <= 1'b1;
                  state    <= LOCKED;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            LOCKED: begin
               if (valid) begin
                  cnt            <= '0;
                  remote_ready_o <= frame_q.rdy;  // Last good frame wins
                  if (frame_q.kind == KIND_DATA) begin
                     rx_valid_o <= 1'b1;
                  end
               end else if (cnt == CNT_W'(FAULT_LIMIT - 1)) begin
                  fault_o <= 1'b1;  // Too many bad frames in a row
                  state   <= FAULT;
               end else begin
                  cnt <= cnt + 1'b1;  // Bad frame dropped
               end
            end
            default: ;  // FAULT holds until reset
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/qeciphy_tx.sv
// Transmit framer
// Training, idle and data frames plus the user req/ack handshake
`default_nettype none

module qeciphy_tx (
   input  wire                         clk_i,
   input  wire                         rst_n_i,
   input  wire                         tx_link_enable_i,  // Training on
   input  wire                         tx_data_enable_i,  // Data frames on
   input  wire                         local_rx_ready_i,  // Into rdy field
   input  wire                         tx_req_i,
   input  wire  [7:0]                  tx_data_i,
   output logic                        tx_ack_o,
   output qeciphy_pkg::qeciphy_frame_t tx_frame_o
);

   import qeciphy_pkg::*;

   typedef enum logic [1:0] {
      IDLE_WAIT,  // Ready for a request
      SEND,       // Data frame on the link now
      HOLD_ACK    // Ack high until req drops
   } tx_state_e;

   tx_state_e      state;
   tx_state_e      state_d;
   qeciphy_frame_t frame_d;
   logic           ack_d;

   always_comb begin
      state_d = state;
      ack_d   = tx_ack_o;
      frame_d = '0;  // KIND_NONE while link disabled

      // Handshake side
      case (state)
         SEND: begin
            ack_d   = 1'b1;  // One cycle after the frame
            state_d = HOLD_ACK;
         end
         HOLD_ACK: begin
            if (!tx_req_i) begin
               ack_d   = 1'b0;
               state_d = IDLE_WAIT;
            end
         end
         default: ;
      endcase

      // Frame selection
      if (tx_link_enable_i) begin
         frame_d.rdy = local_rx_ready_i;
         if (!tx_data_enable_i) begin
            frame_d.kind    = KIND_TRAIN;
            frame_d.payload = TRAIN_PATTERN;
         end else if (state == IDLE_WAIT && tx_req_i) begin
            frame_d.kind    = KIND_DATA;  // Exactly one per request
            frame_d.payload = tx_data_i;
            state_d         = SEND;
         end else begin
            frame_d.kind    = KIND_IDLE;
            frame_d.payload = 8'h00;
         end
         frame_d.check = frame_check(frame_d.payload);
      end
   end

   // Frame register refreshed every cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state      <= IDLE_WAIT;
         tx_ack_o   <= 1'b0;
         tx_frame_o <= '0;
      end else begin
         state      <= state_d;
         tx_ack_o   <= ack_d;
         tx_frame_o <= frame_d;
      end
   end

endmodule

`default_nettype wire

//--- logic/qeciphy_controller.sv
// Link controller
// One-hot bring-up and fault FSM, enable decode and status mapping
`default_nettype none

module qeciphy_controller (
   input  wire                          clk_i,
   input  wire                          rst_n_i,
   // Status from the other blocks
   input  wire                          reset_done_i,           // Reset hold done
   input  wire                          rx_datapath_aligned_i,  // Training seen
   input  wire                          rx_ready_i,             // Local frame lock
   input  wire                          remote_rx_ready_i,      // Far side locked
   input  wire                          fault_fatal_i,          // Lock lost
   // Control and status out
   output logic                         link_ready_o,
   output logic                         fault_fatal_o,
   output logic                         tx_link_enable_o,
   output logic                         tx_data_enable_o,
   output logic                         rx_enable_o,
   output qeciphy_pkg::qeciphy_status_e status_o
);

   import qeciphy_pkg::*;

   // ========================================================================
   // State encoding
   // ========================================================================
   // Bits 10:0 one-hot per state, bits 13:11 carry the enables
   // so each enable is a single state bit

   localparam int TX_DATA_BIT = 13;
   localparam int RX_EN_BIT   = 12;
   localparam int TX_LINK_BIT = 11;
   localparam int FAULT_BIT   = 10;
   localparam int READY_BIT   = 9;

   typedef enum logic [13:0] {
      RESET                  = 14'b000_00000000001,
      WAIT_RESET_DONE        = 14'b000_00000000010,
      TX_LINK_ENABLE         = 14'b001_00000000100,  // Training starts
      WAIT_RX_DATAPATH_ALIGN = 14'b001_00000001000,
      RX_ENABLE              = 14'b011_00000010000,  // Receive lock allowed
      WAIT_RX_LOCKED         = 14'b011_00000100000,
      LOCAL_RX_LOCKED        = 14'b011_00001000000,
      BOTH_RX_LOCKED         = 14'b011_00010000000,
      TX_DATA_ENABLE         = 14'b111_00100000000,  // Data frames allowed
      READY                  = 14'b111_01000000000,
      FAULT_FATAL            = 14'b000_10000000000   // All enables off
   } ctrl_state_e;

   ctrl_state_e state;
   ctrl_state_e state_d;

   // Enables straight off the state bits
   assign tx_data_enable_o = state[TX_DATA_BIT];
   assign rx_enable_o      = state[RX_EN_BIT];
   assign tx_link_enable_o = state[TX_LINK_BIT];
   assign fault_fatal_o    = state[FAULT_BIT];
   assign link_ready_o     = state[READY_BIT];

   // ========================================================================
   // Status mapping
   // ========================================================================

   always_comb begin
      case (state)
         RESET:                  status_o = ST_RESET;
         WAIT_RESET_DONE:        status_o = ST_WAIT_FOR_RESET;
         TX_LINK_ENABLE,
         WAIT_RX_DATAPATH_ALIGN,
         RX_ENABLE,
         WAIT_RX_LOCKED:         status_o = ST_LINK_TRAINING;
         LOCAL_RX_LOCKED,
         BOTH_RX_LOCKED,
         TX_DATA_ENABLE:         status_o = ST_RX_LOCKED;
         READY:                  status_o = ST_LINK_READY;
         FAULT_FATAL:            status_o = ST_FAULT_FATAL;
         default:                status_o = ST_RESET;
      endcase
   end

   // ========================================================================
   // Bring-up sequence
   // ========================================================================

   always_comb begin
      case (state)
         RESET:                  state_d = WAIT_RESET_DONE;
         WAIT_RESET_DONE:        state_d = reset_done_i ? TX_LINK_ENABLE : WAIT_RESET_DONE;
         TX_LINK_ENABLE:         state_d = WAIT_RX_DATAPATH_ALIGN;
         WAIT_RX_DATAPATH_ALIGN: state_d = rx_datapath_aligned_i ? RX_ENABLE
                                                                 : WAIT_RX_DATAPATH_ALIGN;
         RX_ENABLE:              state_d = WAIT_RX_LOCKED;
         WAIT_RX_LOCKED:         state_d = rx_ready_i ? LOCAL_RX_LOCKED : WAIT_RX_LOCKED;
         // Hold here until the far end reports lock
         LOCAL_RX_LOCKED:        state_d = remote_rx_ready_i ? BOTH_RX_LOCKED
                                                             : LOCAL_RX_LOCKED;
         BOTH_RX_LOCKED:         state_d = TX_DATA_ENABLE;
         TX_DATA_ENABLE:         state_d = READY;
         READY:                  state_d = READY;
         FAULT_FATAL:            state_d = FAULT_FATAL;  // Only reset leaves
         default:                state_d = RESET;        // Illegal encoding
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= RESET;
      end else if (fault_fatal_i) begin
         state <= FAULT_FATAL;  // From any state
      end else begin
         state <= state_d;
      end
   end

endmodule

`default_nettype wire

//--- logic/qeciphy_reset_seq.sv
// Reset sequencer
// Holds off reset-done for a fixed number of cycles after reset
`default_nettype none

module qeciphy_reset_seq #(
   parameter int RESET_CYCLES = 8  // Hold time in clock cycles
) (
   input  wire  clk_i,
   input  wire  rst_n_i,
   output logic reset_done_o       // Sticky once set
);

   localparam int CNT_W = $clog2(RESET_CYCLES + 1);

   logic [CNT_W-1:0] cnt;  // Cycles since reset release

   // Stands in for the transceiver reset completion
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt          <= '0;
         reset_done_o <= 1'b0;
      end else if (!reset_done_o) begin
         cnt <= cnt + 1'b1;
         if (cnt == CNT_W'(RESET_CYCLES - 1)) begin
            reset_done_o <= 1'b1;  // Last hold cycle
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/qeciphy_pkg.sv
// Frame, frame kind and status types for the link PHY
// Training pattern constant and frame check helpers
`default_nettype none

package qeciphy_pkg;

   // ========================================================================
   // Frame format
   // ========================================================================

   // Kind of frame on the parallel link
   typedef enum logic [1:0] {
      KIND_NONE  = 2'd0,  // No frame, transmit off
      KIND_TRAIN = 2'd1,  // Training pattern
      KIND_IDLE  = 2'd2,  // Link up, no user data
      KIND_DATA  = 2'd3   // One user byte
   } qeciphy_kind_e;

   // 15-bit parallel frame, kind in the top bits
   typedef struct packed {
      qeciphy_kind_e kind;     // Frame kind
      logic          rdy;      // Sender's receive lock
      logic [7:0]    payload;  // User byte or pattern
      logic [3:0]    check;    // Nibble checksum
   } qeciphy_frame_t;

   localparam logic [7:0] TRAIN_PATTERN = 8'hA5;  // Training payload

   // ========================================================================
   // Link status
   // ========================================================================

   typedef enum logic [3:0] {
      ST_RESET          = 4'd0,
      ST_WAIT_FOR_RESET = 4'd1,
      ST_LINK_TRAINING  = 4'd2,
      ST_RX_LOCKED      = 4'd3,
      ST_LINK_READY     = 4'd4,
      ST_FAULT_FATAL    = 4'd5
   } qeciphy_status_e;

   // Upper nibble XOR lower nibble
   function automatic logic [3:0] frame_check(input logic [7:0] payload);
      return payload[7:4] ^ payload[3:0];
   endfunction

   // Valid = a real kind and a matching checksum
   function automatic logic frame_valid(input qeciphy_frame_t frame);
      return (frame.kind != KIND_NONE) && (frame.check == frame_check(frame.payload));
   endfunction

endpackage

`default_nettype wire
